//--- eth_rx_pkg.sv
`default_nettype none

package eth_rx_pkg;

	////////////////////
	// Plain widths

	// One data byte on the GMII side
	typedef logic [7:0] byte_t;

	// Byte count of a frame, SFD excluded, FCS included
	typedef logic [15:0] frame_len_t;

	// APB address and data
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	////////////////////
	// Beats and streams

	// One receive-clock beat of GMII
	typedef struct packed {
		byte_t data;
		logic  dv;
		logic  er;
	} gmii_rx_t;

	// In-band speed code sent by the PHY in bits 2:1 of an idle byte
	typedef enum logic [1:0] {
		SPEED_10   = 2'b00,
		SPEED_100  = 2'b01,
		SPEED_1000 = 2'b10,
		SPEED_RSVD = 2'b11
	} link_speed_e;

	typedef struct packed {
		logic        link_up;
		link_speed_e speed;
		logic        full_duplex;
	} link_status_t;

	// Forwarded frame stream, last marks the final FCS byte
	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  last;
	} rx_byte_t;

	// Per-frame result
	typedef struct packed {
		logic       crc_ok;
		logic       rx_err;
		frame_len_t length;
	} frame_status_t;

	// Frame control FSM
	typedef enum logic [1:0] {
		IDLE,
		PREAMBLE,
		FRAME,
		DROP
	} ctrl_state_e;

	// Residue left by a good frame, MSB-first bit order
	localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

	////////////////////
	// Register map, byte addresses
	localparam apb_addr_t REG_CTRL    = 8'h00;
	localparam apb_addr_t REG_LINK    = 8'h04;
	localparam apb_addr_t REG_GOOD    = 8'h08;
	localparam apb_addr_t REG_CRC_ERR = 8'h0C;
	localparam apb_addr_t REG_RX_ERR  = 8'h10;
	localparam apb_addr_t REG_DROP    = 8'h14;

endpackage

`default_nettype wire

//--- rgmii_rx_capture.sv
`timescale 1ns/1ps
`default_nettype none

module rgmii_rx_capture import eth_rx_pkg::*; (
	input  wire          gmii_rxc,
	input  wire          rst_n,
	input  wire [3:0]    rgmii_rxd,
	input  wire          rgmii_rx_ctl,
	output gmii_rx_t     gmii,
	output link_status_t link
);

	// Falling-edge half of the pair: high nibble and dv^er
	logic [3:0]   hi_nib_q;
	logic         ctl_fall_q;

	// Rising-edge half of the pair: low nibble and dv
	logic [3:0]   lo_nib_q;
	logic         ctl_rise_q;

	// Rebuilt GMII beat
	byte_t        data_q;
	logic         dv_q;
	logic         er_q;
	link_status_t link_q;

	// Pair seen as a whole just before the next rising edge
	byte_t        pair_byte;
	logic         pair_er;

	////////////////////
	// DDR capture

	always_ff @(negedge gmii_rxc) begin
		hi_nib_q   <= rgmii_rxd;
		ctl_fall_q <= rgmii_rx_ctl;
	end

	always_ff @(posedge gmii_rxc) begin
		lo_nib_q <= rgmii_rxd;
	end

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n) begin
			ctl_rise_q <= 1'b0;
		end else begin
			ctl_rise_q <= rgmii_rx_ctl;
		end
	end

	assign pair_byte = {hi_nib_q, lo_nib_q};

	// Second control bit carries dv XOR er
	assign pair_er = ctl_rise_q ^ ctl_fall_q;

	////////////////////
	// GMII rebuild

	always_ff @(posedge gmii_rxc) begin
		data_q <= pair_byte;
	end

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n) begin
			dv_q <= 1'b0;
			er_q <= 1'b0;
		end else begin
			dv_q <= ctl_rise_q;
			// er without dv is a special symbol, not a frame error
			er_q <= pair_er & ctl_rise_q;
		end
	end

	////////////////////
	// In-band link status

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n) begin
			link_q <= '{link_up: 1'b0, speed: SPEED_10, full_duplex: 1'b0};
		end else if (!ctl_rise_q && !pair_er) begin
			// Plain inter-frame idle
			link_q.link_up     <= pair_byte[0];
			link_q.speed       <= link_speed_e'(pair_byte[2:1]);
			link_q.full_duplex <= pair_byte[3];
		end
	end

	assign gmii = '{data: data_q, dv: dv_q, er: er_q};
	assign link = link_q;

endmodule

`default_nettype wire

//--- eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 import eth_rx_pkg::*; (
	input  wire   gmii_rxc,
	input  wire   rst_n,
	input  wire   crc_init,
	input  wire   crc_en,
	input  byte_t crc_data,
	output logic  crc_match
);

	// Reflected form of the 802.3 polynomial 04C11DB7
	localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;

	logic [31:0] crc_q;
	logic [31:0] crc_next;
	logic [31:0] crc_mirror;

	// Fold one byte in, LSB first as it is sent on the wire
	always_comb begin
		crc_next = crc_q;
		for (int i = 0; i < 8; i++) begin
			crc_next = {1'b0, crc_next[31:1]} ^
				((crc_next[0] ^ crc_data[i]) ? CRC_POLY_REFL : 32'h0);
		end
	end

	// Residue constant is MSB first, register is reflected
	always_comb begin
		for (int i = 0; i < 32; i++) begin
			crc_mirror[i] = crc_next[31 - i];
		end
	end

	// Match for the byte being added this cycle
	assign crc_match = (crc_mirror == CRC_RESIDUE);

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n) begin
			crc_q <= '1;
		end else if (crc_init) begin
			// Preset at the SFD
			crc_q <= '1;
		end else if (crc_en) begin
			crc_q <= crc_next;
		end
	end

endmodule

`default_nettype wire

//--- rx_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_ctrl import eth_rx_pkg::*; (
	input  wire           gmii_rxc,
	input  wire           rst_n,
	input  gmii_rx_t      gmii,
	input  wire           rx_enable,
	output logic          crc_init,
	output logic          crc_en,
	output byte_t         crc_data,
	input  wire           crc_match,
	output rx_byte_t      rx_out,
	output frame_status_t status,
	output logic          status_valid,
	output logic          dropped_pulse
);

	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hD5;

	ctrl_state_e   state_q;
	ctrl_state_e   state_d;

	// One-byte holding register, lets the last byte be flagged when dv drops
	byte_t         hold_q;
	logic          hold_vld_q;

	// Per-frame accumulators
	frame_len_t    len_q;
	logic          err_q;
	logic          match_q;

	// Output registers
	byte_t         out_data_q;
	logic          out_valid_q;
	logic          out_last_q;
	frame_status_t status_q;
	logic          status_valid_q;
	logic          dropped_q;

	logic          sfd_seen;
	logic          in_frame;
	logic          frame_end;

	assign sfd_seen  = (state_q == PREAMBLE) && gmii.dv && (gmii.data == SFD_BYTE);
	assign in_frame  = (state_q == FRAME) && gmii.dv;
	assign frame_end = (state_q == FRAME) && !gmii.dv && hold_vld_q;

	// CRC runs over every byte after the SFD, FCS included
	assign crc_init = sfd_seen;
	assign crc_en   = in_frame;
	assign crc_data = gmii.data;

	////////////////////
	// Next state

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (gmii.dv) begin
					state_d = (gmii.data == PREAMBLE_BYTE) ? PREAMBLE : DROP;
				end
			end
			PREAMBLE: begin
				// Activity that ends before the SFD is ignored
				if (!gmii.dv) begin
					state_d = IDLE;
				end else if (gmii.data == SFD_BYTE) begin
					// Enable is only looked at here
					state_d = rx_enable ? FRAME : DROP;
				end else if (gmii.data != PREAMBLE_BYTE) begin
					state_d = DROP;
				end
			end
			FRAME, DROP: begin
				if (!gmii.dv) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	////////////////////
	// Control flops

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n) begin
			state_q        <= IDLE;
			hold_vld_q     <= 1'b0;
			out_valid_q    <= 1'b0;
			out_last_q     <= 1'b0;
			status_valid_q <= 1'b0;
			dropped_q      <= 1'b0;
		end else begin
			state_q <= state_d;
			if (sfd_seen || frame_end) begin
				hold_vld_q <= 1'b0;
			end else if (in_frame) begin
				hold_vld_q <= 1'b1;
			end
			// Held byte leaves when the next beat arrives or dv drops
			out_valid_q    <= (state_q == FRAME) && hold_vld_q;
			out_last_q     <= frame_end;
			status_valid_q <= frame_end;
			dropped_q      <= sfd_seen && !rx_enable;
		end
	end

	////////////////////
	// Datapath

	always_ff @(posedge gmii_rxc) begin
		if (sfd_seen) begin
			len_q <= '0;
			err_q <= 1'b0;
		end else if (in_frame) begin
			hold_q  <= gmii.data;
			// Saturate, far beyond any legal frame
			len_q   <= (len_q != '1) ? len_q + 1'b1 : len_q;
			err_q   <= err_q | gmii.er;
			match_q <= crc_match;
		end
		out_data_q <= hold_q;
		if (frame_end) begin
			// match_q holds the check for the final FCS byte
			status_q.crc_ok <= match_q;
			status_q.rx_err <= err_q;
			status_q.length <= len_q;
		end
	end

	assign rx_out        = '{data: out_data_q, valid: out_valid_q, last: out_last_q};
	assign status        = status_q;
	assign status_valid  = status_valid_q;
	assign dropped_pulse = dropped_q;

endmodule

`default_nettype wire

//--- rx_stats_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rx_stats_regs import eth_rx_pkg::*; #(
	parameter int CNT_W = 16
) (
	input  wire           gmii_rxc,
	input  wire           rst_n,
	input  apb_addr_t     paddr,
	input  wire           psel,
	input  wire           penable,
	input  wire           pwrite,
	input  apb_data_t     pwdata,
	output apb_data_t     prdata,
	output logic          pready,
	output logic          pslverr,
	input  link_status_t  link,
	input  frame_status_t status,
	input  wire           status_valid,
	input  wire           dropped_pulse,
	output logic          rx_enable
);

	logic [CNT_W-1:0] cnt_good_q;
	logic [CNT_W-1:0] cnt_crc_q;
	logic [CNT_W-1:0] cnt_rxerr_q;
	logic [CNT_W-1:0] cnt_drop_q;

	logic             access;
	logic             addr_hit;
	logic             wr_ctrl;
	logic             clr_cnt;
	logic             inc_good;
	logic             inc_crc;
	logic             inc_rxerr;
	logic             rx_enable_q;

	// Increment that sticks at all ones
	function automatic logic [CNT_W-1:0] sat_inc(
		input logic [CNT_W-1:0] cnt,
		input logic             inc
	);
		sat_inc = (inc && (cnt != '1)) ? cnt + 1'b1 : cnt;
	endfunction

	////////////////////
	// APB decode

	// No wait states, every transfer ends in its access phase
	assign pready = 1'b1;
	assign access = psel && penable;

	assign wr_ctrl = access && pwrite && (paddr == REG_CTRL);
	assign clr_cnt = wr_ctrl && pwdata[1];

	always_comb begin
		prdata   = '0;
		addr_hit = 1'b1;
		case (paddr)
			REG_CTRL:    prdata = apb_data_t'(rx_enable_q);
			// Same bit layout as the in-band idle byte
			REG_LINK:    prdata = apb_data_t'({link.full_duplex, link.speed, link.link_up});
			REG_GOOD:    prdata = apb_data_t'(cnt_good_q);
			REG_CRC_ERR: prdata = apb_data_t'(cnt_crc_q);
			REG_RX_ERR:  prdata = apb_data_t'(cnt_rxerr_q);
			REG_DROP:    prdata = apb_data_t'(cnt_drop_q);
			default:     addr_hit = 1'b0;
		endcase
	end

	assign pslverr = access && !addr_hit;

	////////////////////
	// Control register

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n) begin
			rx_enable_q <= 1'b0;
		end else if (wr_ctrl) begin
			rx_enable_q <= pwdata[0];
		end
	end

	assign rx_enable = rx_enable_q;

	////////////////////
	// Frame counters

	// A receive error wins over the CRC result
	assign inc_good  = status_valid && status.crc_ok && !status.rx_err;
	assign inc_crc   = status_valid && !status.crc_ok && !status.rx_err;
	assign inc_rxerr = status_valid && status.rx_err;

	always_ff @(posedge gmii_rxc) begin
		if (!rst_n || clr_cnt) begin
			cnt_good_q  <= '0;
			cnt_crc_q   <= '0;
			cnt_rxerr_q <= '0;
			cnt_drop_q  <= '0;
		end else begin
			cnt_good_q  <= sat_inc(cnt_good_q, inc_good);
			cnt_crc_q   <= sat_inc(cnt_crc_q, inc_crc);
			cnt_rxerr_q <= sat_inc(cnt_rxerr_q, inc_rxerr);
			cnt_drop_q  <= sat_inc(cnt_drop_q, dropped_pulse);
		end
	end

endmodule

`default_nettype wire

//--- rgmii_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module rgmii_rx_top import eth_rx_pkg::*; #(
	parameter int CNT_W = 16
) (
	input  wire           gmii_rxc,
	input  wire           rst_n,
	// RGMII receive pins
	input  wire [3:0]     rgmii_rxd,
	input  wire           rgmii_rx_ctl,
	// APB register port
	input  apb_addr_t     paddr,
	input  wire           psel,
	input  wire           penable,
	input  wire           pwrite,
	input  apb_data_t     pwdata,
	output apb_data_t     prdata,
	output logic          pready,
	output logic          pslverr,
	// Frame stream and status
	output rx_byte_t      rx_out,
	output frame_status_t status,
	output logic          status_valid
);

	gmii_rx_t     gmii;
	link_status_t link;
	logic         rx_enable;
	logic         crc_init;
	logic         crc_en;
	byte_t        crc_data;
	logic         crc_match;
	logic         dropped_pulse;

	////////////////////
	// Pins to GMII

	rgmii_rx_capture i_capture (
		.gmii_rxc     (gmii_rxc),
		.rst_n        (rst_n),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.gmii         (gmii),
		.link         (link)
	);

	////////////////////
	// Framing and FCS check

	rx_frame_ctrl i_ctrl (
		.gmii_rxc      (gmii_rxc),
		.rst_n         (rst_n),
		.gmii          (gmii),
		.rx_enable     (rx_enable),
		.crc_init      (crc_init),
		.crc_en        (crc_en),
		.crc_data      (crc_data),
		.crc_match     (crc_match),
		.rx_out        (rx_out),
		.status        (status),
		.status_valid  (status_valid),
		.dropped_pulse (dropped_pulse)
	);

	eth_crc32 i_crc (
		.gmii_rxc  (gmii_rxc),
		.rst_n     (rst_n),
		.crc_init  (crc_init),
		.crc_en    (crc_en),
		.crc_data  (crc_data),
		.crc_match (crc_match)
	);

	////////////////////
	// Registers

	rx_stats_regs #(
		.CNT_W (CNT_W)
	) i_regs (
		.gmii_rxc      (gmii_rxc),
		.rst_n         (rst_n),
		.paddr         (paddr),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.link          (link),
		.status        (status),
		.status_valid  (status_valid),
		.dropped_pulse (dropped_pulse),
		.rx_enable     (rx_enable)
	);

endmodule

`default_nettype wire

//--- tb_rgmii_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rgmii_rx import eth_rx_pkg::*; ();

	// Cap on every wait loop in clock cycles
	localparam int MAX_WAIT = 2000;

	logic             gmii_rxc;
	logic             rst_n;
	logic [3:0]       rgmii_rxd;
	logic             rgmii_rx_ctl;
	apb_addr_t        paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	apb_data_t        pwdata;
	apb_data_t        prdata;
	logic             pready;
	logic             pslverr;
	rx_byte_t         rx_out;
	frame_status_t    status;
	logic             status_valid;

	// Beats waiting for the pins as {er, dv, data}
	logic [9:0]       beat_q[$];
	logic [9:0]       beat;
	byte_t            idle_byte;
	byte_t            payload[0:255];

	// Stim file parsing
	int               fd;
	int               code;
	logic [7:0]       tok;
	logic [8*256-1:0] line;
	logic             at_eof;
	apb_addr_t        addr;
	apb_data_t        data;
	apb_data_t        rdata;
	logic             rerr;
	int               exp_err;
	int               n;
	int               err_idx;
	int               flip;
	int               fwd;
	int               cnt;

	rgmii_rx_top #(
		.CNT_W (16)
	) i_dut (
		.gmii_rxc     (gmii_rxc),
		.rst_n        (rst_n),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.rx_out       (rx_out),
		.status       (status),
		.status_valid (status_valid)
	);

	initial begin
		gmii_rxc = 1'b0;
		forever begin
			#4 gmii_rxc = ~gmii_rxc;
		end
	end

	////////////////////
	// RGMII pin driver

	// Low nibble and dv settle before the rising edge
	// High nibble and dv^er go out just after it for the falling-edge flop
	initial begin
		rgmii_rxd    = 4'h0;
		rgmii_rx_ctl = 1'b0;
		forever begin
			@(negedge gmii_rxc);
			#1;
			// Nothing queued means inter-frame idle with the link byte
			beat = (beat_q.size() > 0) ? beat_q.pop_front() : {2'b00, idle_byte};
			rgmii_rxd    = beat[3:0];
			rgmii_rx_ctl = beat[8];
			@(posedge gmii_rxc);
			#1;
			rgmii_rxd    = beat[7:4];
			rgmii_rx_ctl = beat[8] ^ beat[9];
		end
	end

	////////////////////
	// Failure reporting

	task automatic abort_run(input string text);
		$display("%s", text);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", text);
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("FAILED at %0d ns: %s", $time, msg));
	endtask

	////////////////////
	// Helpers

	task automatic wait_beats_sent();
		int waited;
		waited = 0;
		while (beat_q.size() > 0) begin
			@(negedge gmii_rxc);
			waited++;
			if (waited > MAX_WAIT) begin
				abort_run("Timeout: the RGMII beats were never all sent");
			end
		end
	endtask

	// One APB transfer sampled in the middle of the access phase
	task automatic apb_access(input logic wr, input apb_addr_t a, input apb_data_t wd,
			output apb_data_t rd, output logic err);
		int waited;
		waited = 0;
		@(posedge gmii_rxc);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = a;
		pwdata  = wd;
		@(posedge gmii_rxc);
		#1;
		penable = 1'b1;
		@(negedge gmii_rxc);
		while (!pready) begin
			waited++;
			if (waited > MAX_WAIT) begin
				abort_run("Timeout: APB slave never raised pready");
			end
			@(negedge gmii_rxc);
		end
		rd  = prdata;
		err = pslverr;
		@(posedge gmii_rxc);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// Reflected 802.3 FCS of the payload that goes out low byte first
	function automatic logic [31:0] frame_fcs(input int len);
		logic [31:0] crc;
		byte_t       b;
		logic        fb;
		crc = '1;
		for (int i = 0; i < len; i++) begin
			b = payload[i];
			for (int k = 0; k < 8; k++) begin
				fb  = crc[0] ^ b[k];
				crc = crc >> 1;
				if (fb) begin
					crc = crc ^ 32'hEDB88320;
				end
			end
		end
		return ~crc;
	endfunction

	// Sends preamble, SFD, payload, FCS and a random gap and checks the stream
	task automatic run_frame(input int len, input int err_at, input logic bad_fcs,
			input logic expect_fwd);
		byte_t       exp_q[$];
		logic [31:0] fcs;
		int          gap;
		int          idx;
		int          waited;
		logic        seen_last;
		repeat (7) beat_q.push_back({2'b01, 8'h55});
		beat_q.push_back({2'b01, 8'hD5});
		for (int i = 0; i < len; i++) begin
			// err_at counts payload bytes from 1 and is 0 for a clean frame
			beat_q.push_back({(i + 1 == err_at), 1'b1, payload[i]});
			exp_q.push_back(payload[i]);
		end
		fcs = frame_fcs(len);
		if (bad_fcs) begin
			fcs[31:24] = ~fcs[31:24];
		end
		for (int k = 0; k < 4; k++) begin
			beat_q.push_back({2'b01, fcs[8*k +: 8]});
			exp_q.push_back(fcs[8*k +: 8]);
		end
		gap = 12 + int'($urandom % 29);
		repeat (gap) beat_q.push_back({2'b00, idle_byte});
		idx       = 0;
		waited    = 0;
		seen_last = 1'b0;
		// Outputs are stable at the falling edge
		while (beat_q.size() > 0 || (expect_fwd && !seen_last)) begin
			@(negedge gmii_rxc);
			waited++;
			if (waited > MAX_WAIT) begin
				abort_run("Timeout: frame was not fully received");
			end
			if (rx_out.valid) begin
				assert (expect_fwd && idx < exp_q.size()) else
					value_error($sformatf("unexpected byte %02h on rx_out", rx_out.data));
				assert (rx_out.data == exp_q[idx]) else
					value_error($sformatf("byte %0d is %02h, expected %02h",
						idx, rx_out.data, exp_q[idx]));
				assert (rx_out.last == (idx == exp_q.size() - 1)) else
					value_error($sformatf("last is %0b on byte %0d", rx_out.last, idx));
				assert (status_valid == rx_out.last) else
					value_error("status_valid not aligned with the last byte");
				if (rx_out.last) begin
					assert (status.crc_ok == !bad_fcs) else
						value_error($sformatf("crc_ok is %0b", status.crc_ok));
					assert (status.rx_err == (err_at != 0)) else
						value_error($sformatf("rx_err is %0b", status.rx_err));
					assert (status.length == 16'(len + 4)) else
						value_error($sformatf("length is %0d, expected %0d",
							status.length, len + 4));
					seen_last = 1'b1;
				end
				idx++;
			end else begin
				assert (!status_valid) else
					value_error("status_valid without a last byte");
			end
		end
	endtask

	////////////////////
	// Main sequence

	initial begin
		rst_n     = 1'b0;
		paddr     = '0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		pwdata    = '0;
		idle_byte = 8'h00;
		at_eof    = 1'b0;
		void'($urandom(12));
		repeat (16) @(posedge gmii_rxc);
		#1;
		rst_n = 1'b1;
		@(negedge gmii_rxc);
		assert (!rx_out.valid && !status_valid && !pslverr) else
			value_error("outputs not idle after reset");
		fd = $fopen("rgmii_rx_stim.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open rgmii_rx_stim.txt");
		end
		while (!at_eof) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				at_eof = 1'b1;
			end else begin
				case (tok)
					"#": code = $fgets(line, fd);
					"W": begin
						code = $fscanf(fd, "%h %h", addr, data);
						apb_access(1'b1, addr, data, rdata, rerr);
						assert (!rerr) else
							value_error($sformatf("write to %02h got pslverr", addr));
					end
					"R": begin
						code = $fscanf(fd, "%h %h %d", addr, data, exp_err);
						apb_access(1'b0, addr, '0, rdata, rerr);
						assert (rdata == data) else
							value_error($sformatf("read %02h gave %08h, expected %08h",
								addr, rdata, data));
						assert (rerr == exp_err[0]) else
							value_error($sformatf("read %02h pslverr is %0b", addr, rerr));
					end
					"L": begin
						code = $fscanf(fd, "%h %d", idle_byte, cnt);
						repeat (cnt) beat_q.push_back({2'b00, idle_byte});
						wait_beats_sent();
					end
					"F": begin
						code = $fscanf(fd, "%d %d %d %d", n, err_idx, flip, fwd);
						for (int i = 0; i < n; i++) begin
							code = $fscanf(fd, "%h", payload[i]);
							if (code != 1) begin
								abort_run("Stim file ends inside a frame");
							end
						end
						run_frame(n, err_idx, flip[0], fwd[0]);
					end
					default: abort_run("Unknown command in rgmii_rx_stim.txt");
				endcase
			end
		end
		$fclose(fd);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- rgmii_rx_stim.txt
# Commands: W addr data | R addr data pslverr | L link_byte idle_count
# F len err_beat(0 none) flip_fcs forwarded, then len payload bytes in hex
# Receiver disabled after reset, frame is dropped
R 00 00000000 0
R 14 00000000 0
F 16 0 0 0
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
R 14 00000001 0
R 08 00000000 0
# Enable reception, good frames
W 00 00000001
R 00 00000001 0
F 20 0 0 1
ff ff ff ff ff ff 02 00 00 00 00 01 08 06 00 01
08 00 06 04
R 08 00000001 0
F 46 0 0 1
01 00 5e 00 00 fb 02 00 00 00 00 02 08 00 45 00
00 20 12 34 00 00 40 11 00 00 c0 a8 01 02 e0 00
00 fb 14 e9 14 e9 00 0c 00 00 de ad be ef
R 08 00000002 0
# Last FCS byte inverted
F 24 0 1 1
02 00 00 00 00 03 02 00 00 00 00 04 88 b5 10 20
30 40 50 60 70 80 90 a0
R 0C 00000001 0
R 08 00000002 0
# Error beat on payload byte 5
F 18 5 0 1
02 00 00 00 00 05 02 00 00 00 00 06 88 b6 5a a5
c3 3c
R 10 00000001 0
R 0C 00000001 0
# In-band link status, up at 1000 full duplex, then down
L 0D 8
R 04 0000000D 0
L 00 8
R 04 00000000 0
R 20 00000000 1
# Clear counters with reception kept on
W 00 00000003
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
R 00 00000001 0
F 16 0 0 1
d5 55 d5 55 00 01 02 03 04 05 06 07 08 09 0a 0b
R 08 00000001 0

//--- files.f
eth_rx_pkg.sv
rgmii_rx_capture.sv
eth_crc32.sv
rx_frame_ctrl.sv
rx_stats_regs.sv
rgmii_rx_top.sv
tb_rgmii_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RGMII receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_rgmii_rx \
	-f files.f \
	-o sim_rgmii_rx

./obj_dir/sim_rgmii_rx
